// ==== src/llc_mem_cfg.svh ====
////////////////////
// sizes of the llc bank local memory
// include wherever a width or a count is needed
////////////////////

`ifndef LLC_MEM_CFG_SVH
`define LLC_MEM_CFG_SVH

// set indexing
`define LLC_SET_BITS   4
`define LLC_SETS       16

// ways per set
`define LLC_WAY_BITS   2
`define LLC_WAYS       4

// entry fields
`define LLC_TAG_BITS   8
`define LLC_STATE_BITS 3
`define LLC_LINE_BITS  32

`endif

// ==== src/llc_mem_pkg.sv ====
////////////////////
// shared types of the llc local memory, import where used
////////////////////

`include "llc_mem_cfg.svh"

package llc_mem_pkg;

    typedef logic [`LLC_SET_BITS-1:0]   llc_set_t;
    typedef logic [`LLC_WAY_BITS-1:0]   llc_way_t;
    typedef logic [`LLC_TAG_BITS-1:0]   llc_tag_t;
    // 0 is invalid
    typedef logic [`LLC_STATE_BITS-1:0] llc_state_t;
    typedef logic [`LLC_LINE_BITS-1:0]  line_t;

    // dirty on top, state in the middle, tag at the bottom
    typedef logic [`LLC_TAG_BITS+`LLC_STATE_BITS:0] llc_mixed_t;

    typedef enum logic [1:0] {OP_READ, OP_WRITE_ENTRY, OP_WRITE_EVICT} llc_op_e;

    typedef enum logic [1:0] {ACC_IDLE, ACC_WAIT_GNT, ACC_WAIT_DATA, ACC_ACK} access_state_e;

    typedef enum logic [1:0] {FL_IDLE, FL_RUN, FL_ACK} flush_state_e;

endpackage

// ==== src/llc_mem_if.sv ====
////////////////////
// one memory operation and its read data
// clients request, the arbiter grants, the store executes
////////////////////

`timescale 1ns/10ps

interface llc_mem_if import llc_mem_pkg::*; ();

    logic       req;
    logic       gnt;
    logic       rd_en;
    logic       wr_en;
    logic       flush_wr;
    logic       wr_evict;
    llc_set_t   set;
    llc_way_t   way;
    llc_tag_t   wr_tag;
    llc_state_t wr_state;
    logic       wr_dirty;
    line_t      wr_line;
    llc_way_t   wr_evict_way;
    llc_tag_t   rd_tag;
    llc_state_t rd_state;
    logic       rd_dirty;
    line_t      rd_line;
    llc_way_t   rd_evict_way;

    modport client (
        output req, rd_en, wr_en, flush_wr, wr_evict, set, way,
        output wr_tag, wr_state, wr_dirty, wr_line, wr_evict_way,
        input  gnt, rd_tag, rd_state, rd_dirty, rd_line, rd_evict_way
    );

    modport arbiter (
        input  req, rd_en, wr_en, flush_wr, wr_evict, set, way,
        input  wr_tag, wr_state, wr_dirty, wr_line, wr_evict_way,
        output gnt, rd_tag, rd_state, rd_dirty, rd_line, rd_evict_way
    );

    // the store takes one operation per cycle and answers gnt itself
    modport store (
        input  req, rd_en, wr_en, flush_wr, wr_evict, set, way,
        input  wr_tag, wr_state, wr_dirty, wr_line, wr_evict_way,
        output gnt, rd_tag, rd_state, rd_dirty, rd_line, rd_evict_way
    );

endinterface

// ==== src/llc_way_store.sv ====
////////////////////
// tag/state/dirty, line and eviction pointer storage of one llc bank
// one operation per cycle, reads return on the next edge
////////////////////

`timescale 1ns/10ps
`include "llc_mem_cfg.svh"

module llc_way_store import llc_mem_pkg::*; (
    input logic clk,
    input logic rst,
    llc_mem_if.store bus
);

    localparam int state_lo  = `LLC_TAG_BITS;
    localparam int dirty_pos = `LLC_TAG_BITS + `LLC_STATE_BITS;

    // flush touches dirty and state only
    localparam llc_mixed_t flush_mask =
        llc_mixed_t'({1'b1, {`LLC_STATE_BITS{1'b1}}, {`LLC_TAG_BITS{1'b0}}});

    llc_mixed_t wr_mixed;
    llc_mixed_t wr_mask;
    llc_mixed_t rd_mixed [`LLC_WAYS];
    line_t      rd_line_way [`LLC_WAYS];
    llc_mixed_t rd_word;
    llc_way_t   rd_way;
    llc_way_t   rd_evict;
    llc_way_t   evict_mem [`LLC_SETS];

    // always accepts, so any request is granted right away
    assign bus.gnt = bus.req;

    // flush writes carry zero state and dirty
    assign wr_mixed = {bus.wr_dirty, bus.wr_state, bus.wr_tag};
    assign wr_mask  = bus.wr_en ? {$bits(llc_mixed_t){1'b1}} : flush_mask;

    genvar w;
    generate
        for (w = 0; w < `LLC_WAYS; w++) begin : g_way
            llc_mixed_t mixed_mem [`LLC_SETS];
            line_t      line_mem [`LLC_SETS];
            llc_mixed_t mixed_q;
            line_t      line_q;
            logic       we_line;
            logic       we_mixed;

            assign we_line  = bus.wr_en && (bus.way == llc_way_t'(w));
            // a flush hits every way of the set at once
            assign we_mixed = we_line || bus.flush_wr;

            always_ff @(posedge clk) begin
                if (we_mixed) begin
                    mixed_mem[bus.set] <= (mixed_mem[bus.set] & ~wr_mask) |
                                          (wr_mixed & wr_mask);
                end
                if (we_line) begin
                    line_mem[bus.set] <= bus.wr_line;
                end
                if (bus.rd_en) begin
                    mixed_q <= mixed_mem[bus.set];
                    line_q  <= line_mem[bus.set];
                end
            end

            assign rd_mixed[w]    = mixed_q;
            assign rd_line_way[w] = line_q;
        end
    endgenerate

    // eviction pointers start at way 0
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `LLC_SETS; i++) begin
                evict_mem[i] <= '0;
            end
        end else if (bus.wr_evict) begin
            evict_mem[bus.set] <= bus.wr_evict_way;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.rd_en) begin
            rd_way   <= bus.way;
            rd_evict <= evict_mem[bus.set];
        end
    end

    // way select after the per-way read registers
    assign rd_word = rd_mixed[rd_way];

    assign bus.rd_tag       = rd_word[`LLC_TAG_BITS-1:0];
    assign bus.rd_state     = rd_word[dirty_pos-1:state_lo];
    assign bus.rd_dirty     = rd_word[dirty_pos];
    assign bus.rd_line      = rd_line_way[rd_way];
    assign bus.rd_evict_way = rd_evict;

endmodule

// ==== src/llc_mem_arbiter.sv ====
////////////////////
// round robin between host port and flush engine on the shared store
////////////////////

`timescale 1ns/10ps

module llc_mem_arbiter import llc_mem_pkg::*; (
    input logic clk,
    input logic rst,
    llc_mem_if.arbiter host,
    llc_mem_if.arbiter flush,
    llc_mem_if.client mem
);

    logic last_host;
    logic host_win;
    logic flush_win;

    // on a tie the side that did not win last time goes
    assign host_win  = host.req && (!flush.req || !last_host);
    assign flush_win = flush.req && !host_win;

    assign mem.req   = host.req || flush.req;
    assign host.gnt  = host_win && mem.gnt;
    assign flush.gnt = flush_win && mem.gnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            last_host <= 1'b0;
        end else if (mem.gnt) begin
            last_host <= host_win;
        end
    end

    // op bits only pass with a grant
    assign mem.rd_en    = (host.gnt && host.rd_en) || (flush.gnt && flush.rd_en);
    assign mem.wr_en    = (host.gnt && host.wr_en) || (flush.gnt && flush.wr_en);
    assign mem.flush_wr = (host.gnt && host.flush_wr) || (flush.gnt && flush.flush_wr);
    assign mem.wr_evict = (host.gnt && host.wr_evict) || (flush.gnt && flush.wr_evict);

    assign mem.set          = host_win ? host.set : flush.set;
    assign mem.way          = host_win ? host.way : flush.way;
    assign mem.wr_tag       = host_win ? host.wr_tag : flush.wr_tag;
    assign mem.wr_state     = host_win ? host.wr_state : flush.wr_state;
    assign mem.wr_dirty     = host_win ? host.wr_dirty : flush.wr_dirty;
    assign mem.wr_line      = host_win ? host.wr_line : flush.wr_line;
    assign mem.wr_evict_way = host_win ? host.wr_evict_way : flush.wr_evict_way;

    // read data goes to both sides and only the reader uses it
    assign host.rd_tag        = mem.rd_tag;
    assign host.rd_state      = mem.rd_state;
    assign host.rd_dirty      = mem.rd_dirty;
    assign host.rd_line       = mem.rd_line;
    assign host.rd_evict_way  = mem.rd_evict_way;

    assign flush.rd_tag       = mem.rd_tag;
    assign flush.rd_state     = mem.rd_state;
    assign flush.rd_dirty     = mem.rd_dirty;
    assign flush.rd_line      = mem.rd_line;
    assign flush.rd_evict_way = mem.rd_evict_way;

endmodule

// ==== src/llc_access_port.sv ====
////////////////////
// host front end, one four-phase request becomes one store operation
////////////////////

`timescale 1ns/10ps

module llc_access_port import llc_mem_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_i,
    output logic       ack_o,
    input  llc_op_e    op_i,
    input  llc_set_t   set_i,
    input  llc_way_t   way_i,
    input  llc_tag_t   tag_i,
    input  llc_state_t state_i,
    input  logic       dirty_i,
    input  line_t      line_i,
    input  llc_way_t   evict_way_i,
    output llc_tag_t   rd_tag_o,
    output llc_state_t rd_state_o,
    output logic       rd_dirty_o,
    output line_t      rd_line_o,
    output llc_way_t   rd_evict_way_o,
    llc_mem_if.client  bus
);

    access_state_e state;
    access_state_e state_nxt;
    logic          is_read;

    assign is_read = (op_i == OP_READ);

    always_comb begin
        state_nxt = state;
        case (state)
            ACC_IDLE: if (req_i) state_nxt = ACC_WAIT_GNT;
            ACC_WAIT_GNT: if (bus.gnt) state_nxt = is_read ? ACC_WAIT_DATA : ACC_ACK;
            // store answers one edge after the grant
            ACC_WAIT_DATA: state_nxt = ACC_ACK;
            ACC_ACK: if (!req_i) state_nxt = ACC_IDLE;
            default: state_nxt = ACC_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ACC_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // host keeps its fields stable until ack
    assign bus.req          = (state == ACC_WAIT_GNT);
    assign bus.rd_en        = is_read;
    assign bus.wr_en        = (op_i == OP_WRITE_ENTRY);
    assign bus.wr_evict     = (op_i == OP_WRITE_EVICT);
    assign bus.flush_wr     = 1'b0;
    assign bus.set          = set_i;
    assign bus.way          = way_i;
    assign bus.wr_tag       = tag_i;
    assign bus.wr_state     = state_i;
    assign bus.wr_dirty     = dirty_i;
    assign bus.wr_line      = line_i;
    assign bus.wr_evict_way = evict_way_i;

    always_ff @(posedge clk) begin
        if (state == ACC_WAIT_DATA) begin
            rd_tag_o       <= bus.rd_tag;
            rd_state_o     <= bus.rd_state;
            rd_dirty_o     <= bus.rd_dirty;
            rd_line_o      <= bus.rd_line;
            rd_evict_way_o <= bus.rd_evict_way;
        end
    end

    assign ack_o = (state == ACC_ACK);

endmodule

// ==== src/llc_flush_engine.sv ====
////////////////////
// flush sequencer, clears state and dirty of every way, set by set
////////////////////

`timescale 1ns/10ps
`include "llc_mem_cfg.svh"

module llc_flush_engine import llc_mem_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush_req_i,
    output logic      flush_ack_o,
    llc_mem_if.client bus
);

    flush_state_e state;
    flush_state_e state_nxt;
    llc_set_t     set_cnt;
    logic         last_set;

    assign last_set = (set_cnt == llc_set_t'(`LLC_SETS - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            FL_IDLE: if (flush_req_i) state_nxt = FL_RUN;
            FL_RUN: if (bus.gnt && last_set) state_nxt = FL_ACK;
            FL_ACK: if (!flush_req_i) state_nxt = FL_IDLE;
            default: state_nxt = FL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= FL_IDLE;
            set_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == FL_IDLE) begin
                set_cnt <= '0;
            end else if (bus.gnt) begin
                set_cnt <= set_cnt + llc_set_t'(1);
            end
        end
    end

    // req stays up across sets, one set per grant
    assign bus.req          = (state == FL_RUN);
    assign bus.flush_wr     = (state == FL_RUN);
    assign bus.rd_en        = 1'b0;
    assign bus.wr_en        = 1'b0;
    assign bus.wr_evict     = 1'b0;
    assign bus.set          = set_cnt;
    assign bus.way          = '0;
    assign bus.wr_tag       = '0;
    assign bus.wr_state     = '0;
    assign bus.wr_dirty     = 1'b0;
    assign bus.wr_line      = '0;
    assign bus.wr_evict_way = '0;

    assign flush_ack_o = (state == FL_ACK);

endmodule

// ==== src/llc_localmem_top.sv ====
////////////////////
// llc bank local memory with host access port and flush port
////////////////////

`timescale 1ns/10ps

module llc_localmem_top import llc_mem_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_i,
    output logic       ack_o,
    input  llc_op_e    op_i,
    input  llc_set_t   set_i,
    input  llc_way_t   way_i,
    input  llc_tag_t   tag_i,
    input  llc_state_t state_i,
    input  logic       dirty_i,
    input  line_t      line_i,
    input  llc_way_t   evict_way_i,
    output llc_tag_t   rd_tag_o,
    output llc_state_t rd_state_o,
    output logic       rd_dirty_o,
    output line_t      rd_line_o,
    output llc_way_t   rd_evict_way_o,
    input  logic       flush_req_i,
    output logic       flush_ack_o
);

    llc_mem_if host_bus ();
    llc_mem_if flush_bus ();
    llc_mem_if store_bus ();

    llc_access_port i_access_port (
        .clk            (clk),
        .rst            (rst),
        .req_i          (req_i),
        .ack_o          (ack_o),
        .op_i           (op_i),
        .set_i          (set_i),
        .way_i          (way_i),
        .tag_i          (tag_i),
        .state_i        (state_i),
        .dirty_i        (dirty_i),
        .line_i         (line_i),
        .evict_way_i    (evict_way_i),
        .rd_tag_o       (rd_tag_o),
        .rd_state_o     (rd_state_o),
        .rd_dirty_o     (rd_dirty_o),
        .rd_line_o      (rd_line_o),
        .rd_evict_way_o (rd_evict_way_o),
        .bus            (host_bus.client)
    );

    llc_flush_engine i_flush_engine (
        .clk         (clk),
        .rst         (rst),
        .flush_req_i (flush_req_i),
        .flush_ack_o (flush_ack_o),
        .bus         (flush_bus.client)
    );

    llc_mem_arbiter i_mem_arbiter (
        .clk   (clk),
        .rst   (rst),
        .host  (host_bus.arbiter),
        .flush (flush_bus.arbiter),
        .mem   (store_bus.client)
    );

    llc_way_store i_way_store (
        .clk (clk),
        .rst (rst),
        .bus (store_bus.store)
    );

endmodule

// ==== verification/llc_localmem_tb.sv ====
////////////////////
// table driven testbench of the llc local memory
// drives host and flush ports and checks reads against a reference model
////////////////////

`timescale 1ns/10ps
`include "llc_mem_cfg.svh"

module llc_localmem_tb import llc_mem_pkg::*; ();

    localparam int wait_limit = 200;

    typedef enum logic [2:0] {
        ROW_WRITE, ROW_EVICT, ROW_READ, ROW_FLUSH_START, ROW_FLUSH_END
    } row_kind_e;

    // write rows use the write fields and read rows the exp_* fields
    typedef struct packed {
        row_kind_e  kind;
        llc_set_t   set;
        llc_way_t   way;
        llc_tag_t   tag;
        llc_state_t state;
        logic       dirty;
        line_t      line;
        llc_way_t   evict_way;
        logic       chk_entry;
        llc_tag_t   exp_tag;
        llc_state_t exp_state;
        logic       exp_dirty;
        line_t      exp_line;
        llc_way_t   exp_evict;
    } row_t;

    logic       clk;
    logic       rst;
    logic       req_i;
    logic       ack_o;
    llc_op_e    op_i;
    llc_set_t   set_i;
    llc_way_t   way_i;
    llc_tag_t   tag_i;
    llc_state_t state_i;
    logic       dirty_i;
    line_t      line_i;
    llc_way_t   evict_way_i;
    llc_tag_t   rd_tag_o;
    llc_state_t rd_state_o;
    logic       rd_dirty_o;
    line_t      rd_line_o;
    llc_way_t   rd_evict_way_o;
    logic       flush_req_i;
    logic       flush_ack_o;

    // reference model of the arrays
    llc_tag_t    mdl_tag   [`LLC_SETS][`LLC_WAYS];
    llc_state_t  mdl_state [`LLC_SETS][`LLC_WAYS];
    logic        mdl_dirty [`LLC_SETS][`LLC_WAYS];
    line_t       mdl_line  [`LLC_SETS][`LLC_WAYS];
    logic        mdl_known [`LLC_SETS][`LLC_WAYS];
    llc_way_t    mdl_evict [`LLC_SETS];
    logic [15:0] lfsr;
    row_t        rows [$];
    string       row_names [$];

    llc_localmem_top i_llc_localmem_top (
        .clk            (clk),
        .rst            (rst),
        .req_i          (req_i),
        .ack_o          (ack_o),
        .op_i           (op_i),
        .set_i          (set_i),
        .way_i          (way_i),
        .tag_i          (tag_i),
        .state_i        (state_i),
        .dirty_i        (dirty_i),
        .line_i         (line_i),
        .evict_way_i    (evict_way_i),
        .rd_tag_o       (rd_tag_o),
        .rd_state_o     (rd_state_o),
        .rd_dirty_o     (rd_dirty_o),
        .rd_line_o      (rd_line_o),
        .rd_evict_way_o (rd_evict_way_o),
        .flush_req_i    (flush_req_i),
        .flush_ack_o    (flush_ack_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic add_row(string name, row_t r);
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    task automatic add_entry_write(int s, int w);
        row_t r;
        r = '0;
        r.kind  = ROW_WRITE;
        r.set   = llc_set_t'(s);
        r.way   = llc_way_t'(w);
        r.tag   = llc_tag_t'(rand_bits(`LLC_TAG_BITS));
        r.state = llc_state_t'(rand_bits(`LLC_STATE_BITS));
        r.dirty = 1'(rand_bits(1));
        r.line  = line_t'(rand_bits(`LLC_LINE_BITS));
        mdl_tag[s][w]   = r.tag;
        mdl_state[s][w] = r.state;
        mdl_dirty[s][w] = r.dirty;
        mdl_line[s][w]  = r.line;
        mdl_known[s][w] = 1'b1;
        add_row($sformatf("entry_wr_s%0d_w%0d", s, w), r);
    endtask

    task automatic add_evict_write(string name, int s, int evw);
        row_t r;
        r = '0;
        r.kind      = ROW_EVICT;
        r.set       = llc_set_t'(s);
        r.evict_way = llc_way_t'(evw);
        mdl_evict[s] = r.evict_way;
        add_row(name, r);
    endtask

    // entry fields are only compared where the model knows them
    task automatic add_read(string name, int s, int w, logic check_entry);
        row_t r;
        r = '0;
        r.kind      = ROW_READ;
        r.set       = llc_set_t'(s);
        r.way       = llc_way_t'(w);
        r.chk_entry = check_entry && mdl_known[s][w];
        r.exp_tag   = mdl_tag[s][w];
        r.exp_state = mdl_state[s][w];
        r.exp_dirty = mdl_dirty[s][w];
        r.exp_line  = mdl_line[s][w];
        r.exp_evict = mdl_evict[s];
        add_row(name, r);
    endtask

    task automatic add_flush(string name, logic at_end);
        row_t r;
        r = '0;
        r.kind = at_end ? ROW_FLUSH_END : ROW_FLUSH_START;
        if (at_end) begin
            for (int s = 0; s < `LLC_SETS; s++) begin
                for (int w = 0; w < `LLC_WAYS; w++) begin
                    mdl_state[s][w] = '0;
                    mdl_dirty[s][w] = 1'b0;
                end
            end
        end
        add_row(name, r);
    endtask

    task automatic read_known_entries(string prefix);
        for (int s = 0; s < `LLC_SETS; s++) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                if (mdl_known[s][w]) begin
                    add_read($sformatf("%s_s%0d_w%0d", prefix, s, w), s, w, 1'b1);
                end
            end
        end
    endtask

    task automatic build_table();
        for (int s = 0; s < `LLC_SETS; s++) begin
            mdl_evict[s] = '0;
            for (int w = 0; w < `LLC_WAYS; w++) begin
                mdl_known[s][w] = 1'b0;
            end
        end
        for (int s = 0; s < `LLC_SETS; s++) begin
            add_read($sformatf("evict_reset_s%0d", s), s, 0, 1'b1);
        end
        add_entry_write(0, 2);
        add_read("entry_rd_single", 0, 2, 1'b1);
        for (int s = 3; s <= 5; s++) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                add_entry_write(s, w);
            end
        end
        read_known_entries("entry_rd");
        add_evict_write("evict_wr_s4", 4, 3);
        add_evict_write("evict_wr_s5", 5, 2);
        for (int s = 0; s < `LLC_SETS; s++) begin
            add_read($sformatf("evict_rd_s%0d", s), s, 0, 1'b1);
        end
        add_flush("flush_full_start", 1'b0);
        add_flush("flush_full_end", 1'b1);
        read_known_entries("after_flush_rd");
        add_entry_write(6, 1);
        // host traffic while the flush walks the sets
        add_flush("flush_busy_start", 1'b0);
        add_evict_write("busy_evict_wr_s9", 9, 1);
        add_read("busy_evict_rd_s9", 9, 0, 1'b0);
        add_read("busy_evict_rd_s4", 4, 1, 1'b0);
        add_flush("flush_busy_end", 1'b1);
        read_known_entries("final_rd");
        for (int s = 0; s < `LLC_SETS; s++) begin
            add_read($sformatf("evict_final_s%0d", s), s, 1, 1'b1);
        end
    endtask

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_val(string name, string field, logic [31:0] exp, logic [31:0] got);
        assert (got === exp) else begin
            $display("ERR %s %s expected %0h actual %0h", name, field, exp, got);
            abort_run();
        end
    endtask

    task automatic wait_host_ack(string name, logic level);
        int n;
        n = 0;
        while (ack_o !== level && n < wait_limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        assert (ack_o === level) else begin
            $display("timeout in %s, ack_o never went to %b", name, level);
            abort_run();
        end
    endtask

    task automatic wait_flush_ack(string name, logic level);
        int n;
        n = 0;
        while (flush_ack_o !== level && n < wait_limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        assert (flush_ack_o === level) else begin
            $display("timeout in %s, flush_ack_o never went to %b", name, level);
            abort_run();
        end
    endtask

    task automatic run_host(row_t r, string name);
        @(posedge clk);
        #1;
        case (r.kind)
            ROW_WRITE: op_i = OP_WRITE_ENTRY;
            ROW_EVICT: op_i = OP_WRITE_EVICT;
            default:   op_i = OP_READ;
        endcase
        set_i       = r.set;
        way_i       = r.way;
        tag_i       = r.tag;
        state_i     = r.state;
        dirty_i     = r.dirty;
        line_i      = r.line;
        evict_way_i = r.evict_way;
        req_i       = 1'b1;
        wait_host_ack(name, 1'b1);
        // read outputs hold while ack_o is high
        if (r.kind == ROW_READ) begin
            check_val(name, "evict_way", 32'(r.exp_evict), 32'(rd_evict_way_o));
            if (r.chk_entry) begin
                check_val(name, "tag", 32'(r.exp_tag), 32'(rd_tag_o));
                check_val(name, "state", 32'(r.exp_state), 32'(rd_state_o));
                check_val(name, "dirty", 32'(r.exp_dirty), 32'(rd_dirty_o));
                check_val(name, "line", r.exp_line, rd_line_o);
            end
        end
        req_i = 1'b0;
        wait_host_ack(name, 1'b0);
    endtask

    task automatic run_row(row_t r, string name);
        if (r.kind == ROW_FLUSH_START) begin
            @(posedge clk);
            #1;
            flush_req_i = 1'b1;
        end else if (r.kind == ROW_FLUSH_END) begin
            wait_flush_ack(name, 1'b1);
            @(posedge clk);
            #1;
            check_val(name, "flush_ack_held", 32'd1, 32'(flush_ack_o));
            flush_req_i = 1'b0;
            wait_flush_ack(name, 1'b0);
        end else begin
            run_host(r, name);
        end
    endtask

    initial begin
        rst         = 1'b0;
        req_i       = 1'b0;
        op_i        = OP_READ;
        set_i       = '0;
        way_i       = '0;
        tag_i       = '0;
        state_i     = '0;
        dirty_i     = 1'b0;
        line_i      = '0;
        evict_way_i = '0;
        flush_req_i = 1'b0;
        lfsr        = 16'd42425;
        build_table();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;
        check_val("reset", "ack_o", 32'd0, 32'(ack_o));
        check_val("reset", "flush_ack_o", 32'd0, 32'(flush_ack_o));
        for (int i = 0; i < rows.size(); i++) begin
            run_row(rows[i], row_names[i]);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+src
src/llc_mem_pkg.sv
src/llc_mem_if.sv
src/llc_way_store.sv
src/llc_mem_arbiter.sv
src/llc_access_port.sv
src/llc_flush_engine.sv
src/llc_localmem_top.sv
verification/llc_localmem_tb.sv

// ==== Makefile ====
# Verilator build and run of the llc local memory testbench

VERILATOR ?= verilator
TOP       ?= llc_localmem_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0 --timescale 1ns/10ps
PASS_TEXT ?= All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
